//--- logic/shader_pkg.sv
`default_nettype none

package shader_pkg;

    localparam int word_width = 32;
    localparam int address_width = 16;        // Byte address
    localparam int ram_index_width = 10;
    localparam int ram_words = 1 << ram_index_width;

    // Request word fields
    localparam int run_bit = 30;
    localparam int request_bit = 29;

    localparam logic [7:0] cmd_put_low = 8'd0;
    localparam logic [7:0] cmd_put_high = 8'd1;
    localparam logic [7:0] cmd_write_inst = 8'd2;
    localparam logic [7:0] cmd_write_data = 8'd3;
    localparam logic [7:0] cmd_read_inst = 8'd4;
    localparam logic [7:0] cmd_read_data = 8'd5;
    localparam logic [7:0] cmd_read_x_reg = 8'd6;
    localparam logic [7:0] cmd_read_special = 8'd8;
    localparam logic [7:0] cmd_get_low = 8'd9;
    localparam logic [7:0] cmd_get_high = 8'd10;

    localparam logic [address_width-1:0] special_pc = 16'd0;

    // Status word fields
    localparam int status_exited_reset = 31;
    localparam int status_busy = 30;
    localparam int status_cmd_error = 29;
    localparam int status_halted = 28;
    localparam int status_exception = 27;

    localparam logic [23:0] err_unknown_cmd = 24'hdead00;

    // RV32I subset
    localparam logic [6:0] op_imm = 7'b0010011;
    localparam logic [6:0] op_reg = 7'b0110011;
    localparam logic [6:0] op_load = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;
    localparam logic [6:0] op_system = 7'b1110011;
    localparam logic [2:0] funct3_add = 3'b000;
    localparam logic [2:0] funct3_word = 3'b010;   // lw and sw
    localparam logic [24:0] ebreak_fields = 25'h0002000;

    // Core FSM
    localparam logic [1:0] st_fetch = 2'd0;
    localparam logic [1:0] st_execute = 2'd1;
    localparam logic [1:0] st_load_wait = 2'd2;

    // Host command FSM
    localparam logic [1:0] eng_idle = 2'd0;
    localparam logic [1:0] eng_finish = 2'd1;
    localparam logic [1:0] eng_ram_wait = 2'd2;
    localparam logic [1:0] eng_ram_latch = 2'd3;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } i;
        struct packed {
            logic [6:0] imm_high;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_low;
            logic [6:0] opcode;
        } s;
    } instruction_t;

endpackage

`default_nettype wire

//--- logic/block_ram.sv
`timescale 1ns/1ns
`default_nettype none

module block_ram
    import shader_pkg::*;
(
    input wire clock,
    input wire [ram_index_width-1:0] index,
    input wire write,
    input wire [word_width-1:0] write_data,
    output logic [word_width-1:0] read_data
);

    logic [word_width-1:0] memory [ram_words];

    // Read returns the old word on a write cycle
    always_ff @(posedge clock) begin
        if (write) begin
            memory[index] <= write_data;
        end
        read_data <= memory[index];
    end

    write_data_known: assert property (
        @(posedge clock) write |-> !$isunknown(write_data)
    );

endmodule

`default_nettype wire

//--- logic/shader_core.sv
`timescale 1ns/1ns
`default_nettype none

module shader_core
    import shader_pkg::*;
(
    input wire clock,
    input wire reset_n,
    input wire run,
    input wire [word_width-1:0] inst_read_data,
    input wire [word_width-1:0] data_read_data,
    input wire [4:0] debug_reg_number,
    output logic [ram_index_width-1:0] inst_index,
    output logic [ram_index_width-1:0] data_index,
    output logic data_write,
    output logic [word_width-1:0] data_write_data,
    output logic halted,
    output logic exception,
    output logic [word_width-1:0] pc,
    output logic [word_width-1:0] debug_reg_value
);

    logic [1:0] state;
    logic [word_width-1:0] regs [32];     // regs[0] is never written
    instruction_t inst;
    logic [word_width-1:0] rs1_value;
    logic [word_width-1:0] rs2_value;
    logic [word_width-1:0] imm_i;
    logic [word_width-1:0] imm_s;
    logic [word_width-1:0] address;
    logic is_addi;
    logic is_add;
    logic is_lw;
    logic is_sw;
    logic is_ebreak;
    logic misaligned;
    logic active;

    assign inst = inst_read_data;
    assign rs1_value = regs[inst.r.rs1];
    assign rs2_value = regs[inst.r.rs2];
    assign imm_i = {{20{inst.i.imm[11]}}, inst.i.imm};
    assign imm_s = {{20{inst.s.imm_high[6]}}, inst.s.imm_high, inst.s.imm_low};

    assign is_addi = inst.i.opcode == op_imm && inst.i.funct3 == funct3_add;
    assign is_add = inst.r.opcode == op_reg && inst.r.funct3 == funct3_add
                    && inst.r.funct7 == 7'd0;
    assign is_lw = inst.i.opcode == op_load && inst.i.funct3 == funct3_word;
    assign is_sw = inst.s.opcode == op_store && inst.s.funct3 == funct3_word;
    assign is_ebreak = inst.r.opcode == op_system && inst[31:7] == ebreak_fields;

    // Shared adder for addi results and load/store addresses
    assign address = rs1_value + (is_sw ? imm_s : imm_i);
    assign misaligned = (is_lw || is_sw) && address[1:0] != 2'b00;
    assign active = run && !halted && !exception;

    assign inst_index = pc[ram_index_width+1:2];
    assign data_index = address[ram_index_width+1:2];
    assign data_write_data = rs2_value;
    assign data_write = active && state == st_execute && is_sw && !misaligned;
    assign debug_reg_value = regs[debug_reg_number];

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state <= st_fetch;
            pc <= '0;
            halted <= 1'b0;
            exception <= 1'b0;
            for (int n = 0; n < 32; n++) begin
                regs[n] <= '0;
            end
        end else if (!active) begin
            // Host owns the RAMs now, refetch once run returns
            state <= st_fetch;
        end else begin
            case (state)
                st_fetch: begin
                    state <= st_execute;       // Index out now, word arrives next cycle
                end
                st_execute: begin
                    if (is_ebreak) begin
                        halted <= 1'b1;
                    end else if (!(is_addi || is_add || is_lw || is_sw) || misaligned) begin
                        exception <= 1'b1;
                    end else if (is_lw) begin
                        state <= st_load_wait;
                    end else begin
                        if ((is_addi || is_add) && inst.r.rd != 5'd0) begin
                            regs[inst.r.rd] <= is_add ? rs1_value + rs2_value : address;
                        end
                        pc <= pc + 32'd4;
                        state <= st_fetch;
                    end
                end
                st_load_wait: begin
                    // pc still points at the lw, so the word is still decoded
                    if (inst.i.rd != 5'd0) begin
                        regs[inst.i.rd] <= data_read_data;
                    end
                    pc <= pc + 32'd4;
                    state <= st_fetch;
                end
                default: begin
                    state <= st_fetch;
                end
            endcase
        end
    end

    flags_exclusive: assert property (
        @(posedge clock) disable iff (!reset_n) !(halted && exception)
    );

    no_write_when_halted: assert property (
        @(posedge clock) disable iff (!reset_n) halted |-> !data_write
    );

endmodule

`default_nettype wire

//--- logic/host_command_engine.sv
`timescale 1ns/1ns
`default_nettype none

module host_command_engine
    import shader_pkg::*;
(
    input wire clock,
    input wire reset_n,
    input wire [word_width-1:0] request_word,
    input wire [word_width-1:0] inst_read_data,
    input wire [word_width-1:0] data_read_data,
    input wire [ram_index_width-1:0] core_inst_index,
    input wire [ram_index_width-1:0] core_data_index,
    input wire core_data_write,
    input wire [word_width-1:0] core_data_write_data,
    input wire core_halted,
    input wire core_exception,
    input wire [word_width-1:0] core_pc,
    input wire [word_width-1:0] core_debug_value,
    output logic [word_width-1:0] status_word,
    output logic run,
    output logic [4:0] debug_reg_number,
    output logic [ram_index_width-1:0] inst_index,
    output logic inst_write,
    output logic [word_width-1:0] inst_write_data,
    output logic [ram_index_width-1:0] data_index,
    output logic data_write,
    output logic [word_width-1:0] data_write_data
);

    logic request;
    logic request_prev;
    logic accept;
    logic [7:0] command;
    logic [7:0] cmd_latched;
    logic [address_width-1:0] param_field;
    logic [address_width-1:0] cmd_parameter;
    logic [1:0] state;
    logic exited_reset;
    logic busy;
    logic cmd_error;
    logic [23:0] data_field;
    logic [word_width-1:0] write_register;
    logic [word_width-1:0] read_register;
    logic host_inst_write;
    logic host_data_write;
    logic [ram_index_width-1:0] host_index;

    assign run = request_word[run_bit];
    assign request = request_word[request_bit];
    assign command = request_word[23:16];
    assign param_field = request_word[15:0];

    // Rising request edge only, and never while the core owns the RAMs
    assign accept = request && !request_prev && !run && state == eng_idle;

    assign host_index = cmd_parameter[ram_index_width+1:2];
    assign debug_reg_number = cmd_parameter[4:0];

    assign inst_index = run ? core_inst_index : host_index;
    assign inst_write = host_inst_write && !run;
    assign inst_write_data = write_register;
    assign data_index = run ? core_data_index : host_index;
    assign data_write = run ? core_data_write : host_data_write;
    assign data_write_data = run ? core_data_write_data : write_register;

    always_comb begin
        status_word = '0;
        status_word[status_exited_reset] = exited_reset;
        status_word[status_busy] = busy;
        status_word[status_cmd_error] = cmd_error;
        status_word[status_halted] = core_halted;
        status_word[status_exception] = core_exception;
        status_word[23:0] = data_field;
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            request_prev <= 1'b0;
            state <= eng_idle;
            exited_reset <= 1'b0;
            busy <= 1'b0;
            cmd_error <= 1'b0;
            data_field <= '0;
            write_register <= '0;
            read_register <= '0;
            host_inst_write <= 1'b0;
            host_data_write <= 1'b0;
            cmd_latched <= '0;
            cmd_parameter <= '0;
        end else begin
            request_prev <= request;
            exited_reset <= 1'b1;
            host_inst_write <= 1'b0;           // Writes last one cycle
            host_data_write <= 1'b0;
            case (state)
                eng_idle: begin
                    if (accept) begin
                        busy <= 1'b1;
                        cmd_error <= 1'b0;
                        cmd_latched <= command;
                        cmd_parameter <= param_field;
                        state <= eng_finish;
                        case (command)
                            cmd_put_low: write_register[15:0] <= param_field;
                            cmd_put_high: write_register[31:16] <= param_field;
                            cmd_write_inst: host_inst_write <= 1'b1;
                            cmd_write_data: host_data_write <= 1'b1;
                            cmd_read_inst: state <= eng_ram_wait;
                            cmd_read_data: state <= eng_ram_wait;
                            cmd_read_x_reg: state <= eng_finish;
                            cmd_read_special: state <= eng_finish;
                            cmd_get_low: data_field <= {8'd0, read_register[15:0]};
                            cmd_get_high: data_field <= {8'd0, read_register[31:16]};
                            default: begin
                                cmd_error <= 1'b1;
                                data_field <= err_unknown_cmd;
                            end
                        endcase
                    end
                end
                eng_finish: begin
                    // Register reads settle from the latched parameter
                    if (cmd_latched == cmd_read_x_reg) begin
                        read_register <= core_debug_value;
                    end else if (cmd_latched == cmd_read_special) begin
                        read_register <= cmd_parameter == special_pc ? core_pc : '0;
                    end
                    busy <= 1'b0;
                    state <= eng_idle;
                end
                eng_ram_wait: begin
                    state <= eng_ram_latch;            // RAM read latency
                end
                eng_ram_latch: begin
                    read_register <= cmd_latched == cmd_read_inst ? inst_read_data
                                                                  : data_read_data;
                    busy <= 1'b0;
                    state <= eng_idle;
                end
                default: begin
                    state <= eng_idle;
                end
            endcase
        end
    end

    // Instruction RAM is only written right after an accepted host command
    inst_write_host_only: assert property (
        @(posedge clock) disable iff (!reset_n) inst_write |-> !run && $past(accept)
    );

endmodule

`default_nettype wire

//--- logic/shader_top.sv
`timescale 1ns/1ns
`default_nettype none

module shader_top
    import shader_pkg::*;
(
    input wire clock,
    input wire reset_n,
    input wire [word_width-1:0] request_word,
    output logic [word_width-1:0] status_word
);

    logic run;
    logic [4:0] debug_reg_number;
    logic [word_width-1:0] debug_reg_value;
    logic [word_width-1:0] core_pc;
    logic core_halted;
    logic core_exception;

    // RAM ports after the host/core multiplexer
    logic [ram_index_width-1:0] inst_index;
    logic inst_write;
    logic [word_width-1:0] inst_write_data;
    logic [word_width-1:0] inst_read_data;
    logic [ram_index_width-1:0] data_index;
    logic data_write;
    logic [word_width-1:0] data_write_data;
    logic [word_width-1:0] data_read_data;

    // Core side of the multiplexer
    logic [ram_index_width-1:0] core_inst_index;
    logic [ram_index_width-1:0] core_data_index;
    logic core_data_write;
    logic [word_width-1:0] core_data_write_data;

    host_command_engine engine (
        .clock(clock),
        .reset_n(reset_n),
        .request_word(request_word),
        .inst_read_data(inst_read_data),
        .data_read_data(data_read_data),
        .core_inst_index(core_inst_index),
        .core_data_index(core_data_index),
        .core_data_write(core_data_write),
        .core_data_write_data(core_data_write_data),
        .core_halted(core_halted),
        .core_exception(core_exception),
        .core_pc(core_pc),
        .core_debug_value(debug_reg_value),
        .status_word(status_word),
        .run(run),
        .debug_reg_number(debug_reg_number),
        .inst_index(inst_index),
        .inst_write(inst_write),
        .inst_write_data(inst_write_data),
        .data_index(data_index),
        .data_write(data_write),
        .data_write_data(data_write_data)
    );

    block_ram inst_ram (
        .clock(clock),
        .index(inst_index),
        .write(inst_write),
        .write_data(inst_write_data),
        .read_data(inst_read_data)
    );

    block_ram data_ram (
        .clock(clock),
        .index(data_index),
        .write(data_write),
        .write_data(data_write_data),
        .read_data(data_read_data)
    );

    shader_core core (
        .clock(clock),
        .reset_n(reset_n),
        .run(run),
        .inst_read_data(inst_read_data),
        .data_read_data(data_read_data),
        .debug_reg_number(debug_reg_number),
        .inst_index(core_inst_index),
        .data_index(core_data_index),
        .data_write(core_data_write),
        .data_write_data(core_data_write_data),
        .halted(core_halted),
        .exception(core_exception),
        .pc(core_pc),
        .debug_reg_value(debug_reg_value)
    );

endmodule

`default_nettype wire

//--- tb/tb_shader_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_shader_top
    import shader_pkg::*;
();

    logic clock;
    logic reset_n;
    logic [31:0] request_word;
    logic [31:0] status_word;

    integer seed = 32'h40c9a0fd;
    int budget = 100;                  // Cycle allowance, grows as the tests go on
    int cycles = 0;

    // Host view of the RAMs and the expected core state
    logic [31:0] inst_model [1024];
    logic [31:0] data_model [1024];
    logic [31:0] ref_regs [32];
    logic [31:0] ref_pc;
    logic ref_halted;
    logic ref_exception;
    logic [31:0] code [$];

    shader_top dut0 (
        .clock(clock),
        .reset_n(reset_n),
        .request_word(request_word),
        .status_word(status_word)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    initial begin
        while (cycles <= budget) begin
            @(posedge clock);
            cycles++;
        end
        $display("Watchdog expired after %0d cycles with the test still running", cycles);
        $display("Result: FAILED");
        $fatal(1, "timeout");
    end

    function automatic logic [31:0] pack_request(input logic run, input logic request,
                                                 input logic [7:0] cmd, input logic [15:0] param);
        logic [31:0] word;
        word = '0;
        word[run_bit] = run;
        word[request_bit] = request;
        word[23:16] = cmd;
        word[15:0] = param;
        return word;
    endfunction

    function automatic logic [31:0] status_flag(input logic [31:0] word, input int position);
        return {31'd0, word[position]};
    endfunction

    function automatic logic [15:0] ram_param(input int index);
        return {4'd0, index[9:0], 2'b00};   // Byte address of a word
    endfunction

    function automatic logic [31:0] encode_i(input logic [6:0] opcode, input logic [2:0] funct3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
        instruction_t word;
        word = '0;
        word.i.imm = imm;
        word.i.rs1 = rs1;
        word.i.funct3 = funct3;
        word.i.rd = rd;
        word.i.opcode = opcode;
        return word;
    endfunction

    function automatic logic [31:0] encode_add(input logic [4:0] rd, input logic [4:0] rs1,
                                               input logic [4:0] rs2);
        instruction_t word;
        word = '0;
        word.r.rs2 = rs2;
        word.r.rs1 = rs1;
        word.r.rd = rd;
        word.r.opcode = op_reg;
        return word;
    endfunction

    function automatic logic [31:0] encode_sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        instruction_t word;
        word = '0;
        word.s.imm_high = imm[11:5];
        word.s.rs2 = rs2;
        word.s.rs1 = rs1;
        word.s.funct3 = 3'b010;
        word.s.imm_low = imm[4:0];
        word.s.opcode = op_store;
        return word;
    endfunction

    // ISA-level interpreter over inst_model and data_model
    function automatic void run_reference();
        instruction_t inst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] address;
        logic [31:0] result;
        logic write_rd;
        int steps;
        steps = 0;
        while (!ref_halted && !ref_exception && steps < 2048) begin
            inst = inst_model[ref_pc[11:2]];
            a = ref_regs[inst.r.rs1];
            b = ref_regs[inst.r.rs2];
            if (inst.s.opcode == op_store) begin
                address = a + {{20{inst.s.imm_high[6]}}, inst.s.imm_high, inst.s.imm_low};
            end else begin
                address = a + {{20{inst.i.imm[11]}}, inst.i.imm};
            end
            write_rd = 1'b1;
            result = address;
            if (inst == 32'h0010_0073) begin
                ref_halted = 1'b1;
                write_rd = 1'b0;
            end else if (inst.i.opcode == op_imm && inst.i.funct3 == 3'b000) begin
                result = address;
            end else if (inst.r.opcode == op_reg && inst.r.funct3 == 3'b000
                         && inst.r.funct7 == 7'd0) begin
                result = a + b;
            end else if (inst.i.opcode == op_load && inst.i.funct3 == 3'b010
                         && address[1:0] == 2'b00) begin
                result = data_model[address[11:2]];
            end else if (inst.s.opcode == op_store && inst.s.funct3 == 3'b010
                         && address[1:0] == 2'b00) begin
                data_model[address[11:2]] = b;
                write_rd = 1'b0;
            end else begin
                ref_exception = 1'b1;          // pc stays on the faulting word
                write_rd = 1'b0;
            end
            if (write_rd && inst.i.rd != 5'd0) begin
                ref_regs[inst.i.rd] = result;
            end
            if (!ref_halted && !ref_exception) begin
                ref_pc = ref_pc + 32'd4;
            end
            steps++;
        end
    endfunction

    task automatic reset_reference();
        for (int n = 0; n < 32; n++) begin
            ref_regs[n] = '0;
        end
        ref_pc = '0;
        ref_halted = 1'b0;
        ref_exception = 1'b0;
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch %s: actual %h expected %h", name, actual, expected);
            $display("Result: FAILED");
            $fatal(1, "check failed");
        end
    endtask

    task automatic apply_reset();
        budget += 20;
        @(posedge clock);
        reset_n <= 1'b0;
        request_word <= '0;
        repeat (4) @(posedge clock);
        reset_n <= 1'b1;
        @(posedge clock);                  // exited_reset sets here
        @(negedge clock);
    endtask

    // Full request handshake, returns the status seen once busy falls
    task automatic issue_command(input logic [7:0] cmd, input logic [15:0] param,
                                 output logic [31:0] status);
        budget += 200;
        @(posedge clock);
        request_word <= pack_request(1'b0, 1'b1, cmd, param);
        @(negedge clock);
        while (!status_word[status_busy]) begin
            @(negedge clock);
        end
        while (status_word[status_busy]) begin
            @(negedge clock);
        end
        status = status_word;
        @(posedge clock);
        request_word <= pack_request(1'b0, 1'b0, cmd, param);
    endtask

    task automatic write_word(input logic [7:0] cmd, input int index, input logic [31:0] value);
        logic [31:0] status;
        issue_command(cmd_put_low, value[15:0], status);
        issue_command(cmd_put_high, value[31:16], status);
        issue_command(cmd, ram_param(index), status);
    endtask

    task automatic read_back(input logic [7:0] cmd, input logic [15:0] param,
                             output logic [31:0] value);
        logic [31:0] low;
        logic [31:0] high;
        issue_command(cmd, param, low);
        issue_command(cmd_get_low, 16'd0, low);
        issue_command(cmd_get_high, 16'd0, high);
        value = {high[15:0], low[15:0]};
    endtask

    task automatic load_code();
        for (int n = 0; n < code.size(); n++) begin
            write_word(cmd_write_inst, n, code[n]);
            inst_model[n] = code[n];
        end
    endtask

    task automatic run_program(input int count);
        budget += 20 * count;
        @(posedge clock);
        request_word <= pack_request(1'b1, 1'b0, 8'd0, 16'd0);
        @(negedge clock);
        while (!status_word[status_halted] && !status_word[status_exception]) begin
            @(negedge clock);
        end
        @(posedge clock);
        request_word <= pack_request(1'b0, 1'b0, 8'd0, 16'd0);
    endtask

    task automatic check_data_window();
        logic [31:0] value;
        for (int n = 64; n < 72; n++) begin
            read_back(cmd_read_data, ram_param(n), value);
            check_value($sformatf("data word %0d", n), value, data_model[n]);
        end
    endtask

    initial begin
        logic [31:0] value;
        logic [31:0] status;
        logic [31:0] r;
        logic [7:0] bad_code;
        int slots [8];
        reset_n = 1'b0;
        request_word = '0;
        reset_reference();
        apply_reset();

        check_value("exited_reset", status_flag(status_word, status_exited_reset), 32'd1);
        check_value("busy", status_flag(status_word, status_busy), 32'd0);
        check_value("cmd_error", status_flag(status_word, status_cmd_error), 32'd0);
        check_value("halted", status_flag(status_word, status_halted), 32'd0);
        check_value("exception", status_flag(status_word, status_exception), 32'd0);

        // Even slots target the instruction RAM, odd slots the data RAM
        for (int n = 0; n < 8; n++) begin
            r = $random(seed);
            slots[n] = {22'd0, r[9:0]};
            value = $random(seed);
            if (n % 2 == 0) begin
                write_word(cmd_write_inst, slots[n], value);
                inst_model[slots[n]] = value;
            end else begin
                write_word(cmd_write_data, slots[n], value);
                data_model[slots[n]] = value;
            end
        end
        for (int n = 0; n < 8; n++) begin
            if (n % 2 == 0) begin
                read_back(cmd_read_inst, ram_param(slots[n]), value);
                check_value($sformatf("inst word %0d", slots[n]), value, inst_model[slots[n]]);
            end else begin
                read_back(cmd_read_data, ram_param(slots[n]), value);
                check_value($sformatf("data word %0d", slots[n]), value, data_model[slots[n]]);
            end
        end

        for (int n = 0; n < 2; n++) begin
            r = $random(seed);
            bad_code = (n == 0) ? 8'd7 : 8'd11 + r[7:0] % 8'd245;
            issue_command(bad_code, r[31:16], status);
            check_value("cmd_error", status_flag(status, status_cmd_error), 32'd1);
            check_value("data field", {8'd0, status[23:0]}, {8'd0, err_unknown_cmd});
            issue_command(cmd_put_low, 16'd0, status);
            check_value("cmd_error", status_flag(status, status_cmd_error), 32'd0);
        end

        // Random program over data words 64 to 71, addressed from x0
        for (int n = 64; n < 72; n++) begin
            value = $random(seed);
            write_word(cmd_write_data, n, value);
            data_model[n] = value;
        end
        code.delete();
        for (int n = 0; n < 24; n++) begin
            r = $random(seed);
            case (r[1:0])
                2'd0: code.push_back(encode_i(op_imm, 3'b000, r[6:2], r[11:7], r[23:12]));
                2'd1: code.push_back(encode_add(r[6:2], r[11:7], r[16:12]));
                2'd2: code.push_back(encode_i(op_load, 3'b010, r[6:2], 5'd0,
                                              {7'd8, r[14:12], 2'b00}));
                default: code.push_back(encode_sw(r[11:7], 5'd0, {7'd8, r[14:12], 2'b00}));
            endcase
        end
        code.push_back(32'h0010_0073);     // ebreak
        load_code();
        run_reference();
        run_program(code.size());
        check_value("halted", status_flag(status_word, status_halted), 32'd1);
        check_value("exception", status_flag(status_word, status_exception), 32'd0);
        check_data_window();
        for (int n = 0; n < 32; n++) begin
            read_back(cmd_read_x_reg, {11'd0, n[4:0]}, value);
            check_value($sformatf("x%0d", n), value, ref_regs[n]);
        end
        read_back(cmd_read_special, special_pc, value);
        check_value("pc", value, ref_pc);

        // Halted is sticky, so the exception program starts from a fresh reset
        apply_reset();
        reset_reference();
        r = $random(seed);
        code.delete();
        code.push_back(encode_i(op_imm, 3'b000, 5'd5, 5'd0, r[11:0]));
        code.push_back(encode_i(op_imm, 3'b000, 5'd6, 5'd0, r[27:16]));
        code.push_back(encode_sw(5'd5, 5'd0, 12'h100));
        code.push_back(encode_sw(5'd6, 5'd0, 12'h104));
        code.push_back(32'hffff_ffff);
        code.push_back(encode_sw(5'd5, 5'd0, 12'h108));
        code.push_back(encode_sw(5'd6, 5'd0, 12'h10c));
        code.push_back(32'h0010_0073);
        load_code();
        run_reference();
        run_program(code.size());
        check_value("exception", status_flag(status_word, status_exception), 32'd1);
        check_value("halted", status_flag(status_word, status_halted), 32'd0);
        check_data_window();
        read_back(cmd_read_special, special_pc, value);
        check_value("pc", value, ref_pc);

        // Host write attempted while run is high
        value = $random(seed);
        if (value == data_model[70]) begin
            value = ~value;
        end
        issue_command(cmd_put_low, value[15:0], status);
        issue_command(cmd_put_high, value[31:16], status);
        budget += 200;
        @(posedge clock);
        request_word <= pack_request(1'b1, 1'b0, 8'd0, 16'd0);
        @(posedge clock);
        request_word <= pack_request(1'b1, 1'b1, cmd_write_data, ram_param(70));
        repeat (6) begin
            @(negedge clock);
            check_value("busy", status_flag(status_word, status_busy), 32'd0);
        end
        @(posedge clock);
        request_word <= pack_request(1'b0, 1'b0, 8'd0, 16'd0);
        read_back(cmd_read_data, ram_param(70), value);
        check_value("data word 70", value, data_model[70]);

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
logic/shader_pkg.sv
logic/block_ram.sv
logic/shader_core.sv
logic/host_command_engine.sv
logic/shader_top.sv
tb/tb_shader_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_shader_top
BUILD_DIR ?= obj_dir
LOG ?= sim.log
FILE_LIST ?= files.f
VERILATOR_FLAGS ?= --binary --timing --assert -j 0

.PHONY: sim clean

# The log decides the result, the simulator status alone is not trusted
sim:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Result: PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
